/* verilog/ex_params.svh */
// Execute stage parameters
`ifndef EX_PARAMS_SVH
`define EX_PARAMS_SVH

// general register and register number widths
`define REG_W 32
`define REG_ADDR_W 5

// load/store offset as it comes from the instruction
`define OFFSET_W 16

// shift amount bits taken from reg1
`define SHAMT_W 5

// exception vector
`define EXC_W 32

// exception bit positions in the vector
`define ADEL_IDX 4
`define ADES_IDX 5
`define OVERFLOW_IDX 12
`define TRAP_IDX 13

`endif

/* verilog/ex_pkg.sv */
// Execute stage types
`include "ex_params.svh"

package ex_pkg;

  typedef logic [`REG_W-1:0] word_t;

  // operation codes follow the decode stage's 8-bit operation bus
  typedef enum logic [7:0] {
    OP_NOP  = 8'b0000_0000,
    OP_SRL  = 8'b0000_0010,
    OP_SRA  = 8'b0000_0011,
    OP_ADD  = 8'b0010_0000,
    OP_ADDU = 8'b0010_0001,
    OP_SUB  = 8'b0010_0010,
    OP_SUBU = 8'b0010_0011,
    OP_AND  = 8'b0010_0100,
    OP_OR   = 8'b0010_0101,
    OP_XOR  = 8'b0010_0110,
    OP_NOR  = 8'b0010_0111,
    OP_SLT  = 8'b0010_1010,
    OP_SLTU = 8'b0010_1011,
    OP_TGE  = 8'b0011_0000,
    OP_TGEU = 8'b0011_0001,
    OP_TLT  = 8'b0011_0010,
    OP_TLTU = 8'b0011_0011,
    OP_TEQ  = 8'b0011_0100,
    OP_TNE  = 8'b0011_0110,
    OP_SLL  = 8'b0111_1100,
    OP_CLZ  = 8'b1011_0000,
    OP_CLO  = 8'b1011_0001,
    OP_LB   = 8'b1110_0000,
    OP_LH   = 8'b1110_0001,
    OP_LW   = 8'b1110_0011,
    OP_LHU  = 8'b1110_0101,
    OP_SB   = 8'b1110_1000,
    OP_SH   = 8'b1110_1001,
    OP_SW   = 8'b1110_1011
  } aluop_e;

  // result class, selects which datapath drives wdata
  typedef enum logic [2:0] {
    SEL_NONE        = 3'b000,
    SEL_LOGIC       = 3'b001,
    SEL_SHIFT       = 3'b010,
    SEL_ARITH       = 3'b100,
    SEL_JUMP_BRANCH = 3'b110
  } alusel_e;

  typedef struct packed {
    aluop_e                 aluop;
    alusel_e                alusel;
    word_t                  reg1;
    word_t                  reg2;
    logic [`OFFSET_W-1:0]   offset;
    word_t                  link_addr;
    logic [`REG_ADDR_W-1:0] wd;
    logic                   wreg;
    logic [`EXC_W-1:0]      exc_in;
  } ex_req_t;

  typedef struct packed {
    aluop_e                 aluop;
    logic [`REG_ADDR_W-1:0] wd;
    logic                   wreg;
    word_t                  wdata;
    word_t                  mem_addr;
    word_t                  store_data;
    logic [`EXC_W-1:0]      exc;
  } ex_res_t;

  typedef struct packed {
    word_t sum;
    logic  ov;
    logic  lt;
    logic  eq;
  } cmp_t;

endpackage

/* verilog/ex_adder_cmp.sv */
// Shared adder and comparator
`include "ex_params.svh"

module ex_adder_cmp (
  input  ex_pkg::ex_req_t req_i,
  output ex_pkg::cmp_t    cmp_o
);

  import ex_pkg::*;

  logic  sub_sel;
  logic  signed_cmp;
  word_t a;
  word_t b;
  word_t b_mux;
  word_t sum;
  logic  a_neg;
  logic  b_neg;
  logic  sum_neg;

  assign a = req_i.reg1;
  assign b = req_i.reg2;

  // subtract for the explicit subtractions and the signed compares
  assign sub_sel = req_i.aluop inside {OP_SUB, OP_SUBU, OP_SLT, OP_TLT, OP_TGE};

  // signed less-than comes from the difference, everything else is unsigned
  assign signed_cmp = req_i.aluop inside {OP_SLT, OP_TLT, OP_TGE};

  assign b_mux = sub_sel ? (~b + word_t'(1)) : b;
  assign sum = a + b_mux;

  assign a_neg = a[`REG_W-1];
  assign b_neg = b[`REG_W-1];
  assign sum_neg = sum[`REG_W-1];

  always_comb
  begin
    cmp_o.sum = sum;
    // like operand signs in but the opposite sign out
    // reg2 counts with its sign flipped when it is subtracted
    cmp_o.ov = (a_neg == (b_neg ^ sub_sel)) && (sum_neg != a_neg);
    if (signed_cmp)
    begin
      // negative vs positive, or same sign with a negative difference
      cmp_o.lt = (a_neg && !b_neg) ||
                 (!a_neg && !b_neg && sum_neg) ||
                 (a_neg && b_neg && sum_neg);
    end
    else
    begin
      cmp_o.lt = (a < b);
    end
    cmp_o.eq = (a == b);
  end

endmodule

/* verilog/ex_alu.sv */
// Execute stage result datapath
`include "ex_params.svh"

module ex_alu (
  input  ex_pkg::ex_req_t req_i,
  input  ex_pkg::cmp_t    cmp_i,
  output ex_pkg::word_t   wdata_o
);

  import ex_pkg::*;

  logic [`SHAMT_W-1:0] shamt;
  word_t               logic_res;
  word_t               shift_res;
  word_t               arith_res;

  // zeros above the highest set bit, all 32 when the word is zero
  function automatic word_t lead_zeros(input word_t w);
    word_t n;
    n = word_t'(`REG_W);
    for (int i = 0; i < `REG_W; i++)
    begin
      if (w[i])
      begin
        n = word_t'(`REG_W - 1 - i);
      end
    end
    return n;
  endfunction

  assign shamt = req_i.reg1[`SHAMT_W-1:0];

  always_comb
  begin
    case (req_i.aluop)
      OP_OR:   logic_res = req_i.reg1 | req_i.reg2;
      OP_AND:  logic_res = req_i.reg1 & req_i.reg2;
      OP_NOR:  logic_res = ~(req_i.reg1 | req_i.reg2);
      OP_XOR:  logic_res = req_i.reg1 ^ req_i.reg2;
      default: logic_res = '0;
    endcase
  end

  // shifts operate on reg2, amount from reg1
  always_comb
  begin
    case (req_i.aluop)
      OP_SLL:  shift_res = req_i.reg2 << shamt;
      OP_SRL:  shift_res = req_i.reg2 >> shamt;
      OP_SRA:  shift_res = word_t'($signed(req_i.reg2) >>> shamt);
      default: shift_res = '0;
    endcase
  end

  always_comb
  begin
    case (req_i.aluop)
      OP_SLT, OP_SLTU:
        arith_res = word_t'(cmp_i.lt);
      OP_ADD, OP_ADDU, OP_SUB, OP_SUBU:
        arith_res = cmp_i.sum;
      OP_CLZ:
        arith_res = lead_zeros(req_i.reg1);
      // leading ones are leading zeros of the inverse
      OP_CLO:
        arith_res = lead_zeros(~req_i.reg1);
      default:
        arith_res = '0;
    endcase
  end

  always_comb
  begin
    case (req_i.alusel)
      SEL_LOGIC:       wdata_o = logic_res;
      SEL_SHIFT:       wdata_o = shift_res;
      SEL_ARITH:       wdata_o = arith_res;
      SEL_JUMP_BRANCH: wdata_o = req_i.link_addr;
      default:         wdata_o = '0;
    endcase
  end

endmodule

/* verilog/ex_except.sv */
// Execute stage exceptions and memory address
`include "ex_params.svh"

module ex_except (
  input  ex_pkg::ex_req_t req_i,
  input  ex_pkg::cmp_t    cmp_i,
  output ex_pkg::word_t   mem_addr_o,
  output logic            wreg_o,
  output ex_pkg::word_t   exc_o
);

  import ex_pkg::*;

  word_t offset_sx;
  logic  trap;
  logic  ov_exc;
  logic  adel;
  logic  ades;
  logic  half_odd;
  logic  word_mis;
  word_t exc_cur;

  // base register plus sign-extended offset
  assign offset_sx = {{(`REG_W-`OFFSET_W){req_i.offset[`OFFSET_W-1]}}, req_i.offset};
  assign mem_addr_o = req_i.reg1 + offset_sx;

  always_comb
  begin
    case (req_i.aluop)
      OP_TEQ:           trap = cmp_i.eq;
      OP_TNE:           trap = !cmp_i.eq;
      OP_TGE, OP_TGEU:  trap = !cmp_i.lt;
      OP_TLT, OP_TLTU:  trap = cmp_i.lt;
      default:          trap = 1'b0;
    endcase
  end

  // only the trapping forms raise overflow, ADDU/SUBU wrap silently
  assign ov_exc = (req_i.aluop inside {OP_ADD, OP_SUB}) && cmp_i.ov;

  assign half_odd = mem_addr_o[0];
  assign word_mis = |mem_addr_o[1:0];

  always_comb
  begin
    adel = 1'b0;
    ades = 1'b0;
    case (req_i.aluop)
      OP_LH, OP_LHU: adel = half_odd;
      OP_LW:         adel = word_mis;
      OP_SH:         ades = half_odd;
      OP_SW:         ades = word_mis;
      default:
      begin
        adel = 1'b0;
        ades = 1'b0;
      end
    endcase
  end

  always_comb
  begin
    exc_cur = '0;
    exc_cur[`TRAP_IDX] = trap;
    exc_cur[`OVERFLOW_IDX] = ov_exc;
    exc_cur[`ADEL_IDX] = adel;
    exc_cur[`ADES_IDX] = ades;
  end

  // decode exceptions ride along with this stage's own
  assign exc_o = exc_cur | req_i.exc_in;

  // an overflowing add or sub must not reach the register file
  assign wreg_o = req_i.wreg && !ov_exc;

endmodule

/* verilog/ex_mem_reg.sv */
// Execute to memory pipeline register

module ex_mem_reg (
  input  logic            clk,
  input  logic            rst_n_i,
  input  ex_pkg::ex_res_t d_i,
  input  logic            d_valid_i,
  output logic            d_ready_o,
  output ex_pkg::ex_res_t q_o,
  output logic            q_valid_o,
  input  logic            q_ready_i
);

  logic load;

  // free slot, or the held item leaves this cycle
  assign d_ready_o = !q_valid_o || q_ready_i;
  assign load = d_valid_i && d_ready_o;

  always_ff @(posedge clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      q_valid_o <= 1'b0;
    end
    else if (d_ready_o)
    begin
      // empties unless a new item arrives on the same edge
      q_valid_o <= d_valid_i;
    end
  end

  // held steady under back-pressure
  always_ff @(posedge clk)
  begin
    if (load)
    begin
      q_o <= d_i;
    end
  end

endmodule

/* verilog/ex_top.sv */
// Execute stage top level

module ex_top (
  input  logic            clk,
  input  logic            rst_n_i,
  input  ex_pkg::ex_req_t req_i,
  input  logic            req_valid_i,
  output logic            req_ready_o,
  output ex_pkg::ex_res_t res_o,
  output logic            res_valid_o,
  input  logic            res_ready_i
);

  import ex_pkg::*;

  cmp_t    cmp;
  word_t   wdata;
  word_t   mem_addr;
  logic    wreg;
  word_t   exc;
  ex_res_t res_d;

  ex_adder_cmp u_adder_cmp (
    .req_i (req_i),
    .cmp_o (cmp)
  );

  ex_alu u_alu (
    .req_i   (req_i),
    .cmp_i   (cmp),
    .wdata_o (wdata)
  );

  ex_except u_except (
    .req_i      (req_i),
    .cmp_i      (cmp),
    .mem_addr_o (mem_addr),
    .wreg_o     (wreg),
    .exc_o      (exc)
  );

  always_comb
  begin
    res_d.aluop = req_i.aluop;
    res_d.wd = req_i.wd;
    res_d.wreg = wreg;
    res_d.wdata = wdata;
    res_d.mem_addr = mem_addr;
    // store data is reg2 as read in decode
    res_d.store_data = req_i.reg2;
    res_d.exc = exc;
  end

  ex_mem_reg u_mem_reg (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .d_i       (res_d),
    .d_valid_i (req_valid_i),
    .d_ready_o (req_ready_o),
    .q_o       (res_o),
    .q_valid_o (res_valid_o),
    .q_ready_i (res_ready_i)
  );

endmodule

/* verification/ex_tb.sv */
// Execute stage testbench
`include "ex_params.svh"

module ex_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import ex_pkg::*;

  // about six times the cycles all tests need with stalls
  localparam int TIMEOUT_CYCLES = 2000;

  logic    clk;
  logic    rst_n_i;
  ex_req_t req_i;
  logic    req_valid_i;
  logic    req_ready_o;
  ex_res_t res_o;
  logic    res_valid_o;
  logic    res_ready_i;

  integer  seed;
  int      cycles = 0;
  logic    stall_en;
  logic    held_v;
  ex_res_t held;
  ex_res_t exp_q[$];

  ex_top uut (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .req_i       (req_i),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .res_o       (res_o),
    .res_valid_o (res_valid_o),
    .res_ready_i (res_ready_i)
  );

  always #5 clk = ~clk;

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic compare_word(input string name, input word_t got, input word_t exp);
    if (got !== exp)
      report_failure($sformatf("mismatch %s: got %h expected %h", name, got, exp));
  endtask

  task automatic compare_exc(input string name, input word_t got, input word_t exp);
    if (got !== exp)
      report_failure($sformatf("mismatch %s: got %h expected %h", name, got, exp));
  endtask

  function automatic word_t rand_word();
    return $random(seed);
  endfunction

  // run of leading bits equal to val, scanning down from the msb
  function automatic word_t count_lead(input word_t w, input logic val);
    word_t n;
    n = '0;
    for (int i = `REG_W - 1; i >= 0; i--)
    begin
      if (w[i] != val)
        break;
      n++;
    end
    return n;
  endfunction

  function automatic ex_req_t build_req(input aluop_e op, input alusel_e sel,
                                        input word_t r1, input word_t r2);
    ex_req_t r;
    word_t   w;
    w = rand_word();
    r.aluop = op;
    r.alusel = sel;
    r.reg1 = r1;
    r.reg2 = r2;
    r.offset = w[`OFFSET_W-1:0];
    r.link_addr = rand_word();
    r.wd = w[20:16];
    r.wreg = 1'b1;
    r.exc_in = '0;
    return r;
  endfunction

  // expected stage result from the instruction rules
  function automatic ex_res_t model(input ex_req_t r);
    ex_res_t             e;
    word_t               a;
    word_t               b;
    logic [`SHAMT_W-1:0] sh;
    logic                lt_s;
    logic                lt_u;
    logic                eq;
    logic                trap;
    logic                ov;
    logic [63:0]         wide;
    a = r.reg1;
    b = r.reg2;
    sh = a[`SHAMT_W-1:0];
    lt_s = $signed(a) < $signed(b);
    lt_u = a < b;
    eq = a == b;
    // true result does not fit in 32 signed bits
    if (r.aluop == OP_SUB)
      wide = 64'($signed(a)) - 64'($signed(b));
    else
      wide = 64'($signed(a)) + 64'($signed(b));
    ov = (r.aluop inside {OP_ADD, OP_SUB}) && (wide[32] != wide[31]);
    case (r.aluop)
      OP_OR:           e.wdata = a | b;
      OP_AND:          e.wdata = a & b;
      OP_NOR:          e.wdata = ~(a | b);
      OP_XOR:          e.wdata = a ^ b;
      OP_SLL:          e.wdata = b << sh;
      OP_SRL:          e.wdata = b >> sh;
      OP_SRA:          e.wdata = (b >> sh) | (b[`REG_W-1] ? ~(word_t'('1) >> sh) : '0);
      OP_ADD, OP_ADDU: e.wdata = a + b;
      OP_SUB, OP_SUBU: e.wdata = a - b;
      OP_SLT:          e.wdata = word_t'(lt_s);
      OP_SLTU:         e.wdata = word_t'(lt_u);
      OP_CLZ:          e.wdata = count_lead(a, 1'b0);
      OP_CLO:          e.wdata = count_lead(a, 1'b1);
      default:         e.wdata = '0;
    endcase
    if (r.alusel == SEL_JUMP_BRANCH)
      e.wdata = r.link_addr;
    else if (r.alusel == SEL_NONE)
      e.wdata = '0;
    case (r.aluop)
      OP_TEQ:  trap = eq;
      OP_TNE:  trap = !eq;
      OP_TGE:  trap = !lt_s;
      OP_TGEU: trap = !lt_u;
      OP_TLT:  trap = lt_s;
      OP_TLTU: trap = lt_u;
      default: trap = 1'b0;
    endcase
    e.mem_addr = a + word_t'(int'($signed(r.offset)));
    e.exc = r.exc_in;
    e.exc[`TRAP_IDX] = e.exc[`TRAP_IDX] | trap;
    e.exc[`OVERFLOW_IDX] = e.exc[`OVERFLOW_IDX] | ov;
    if ((r.aluop inside {OP_LH, OP_LHU} && e.mem_addr[0]) ||
        (r.aluop == OP_LW && e.mem_addr[1:0] != 2'b00))
      e.exc[`ADEL_IDX] = 1'b1;
    if ((r.aluop == OP_SH && e.mem_addr[0]) ||
        (r.aluop == OP_SW && e.mem_addr[1:0] != 2'b00))
      e.exc[`ADES_IDX] = 1'b1;
    e.aluop = r.aluop;
    e.wd = r.wd;
    e.wreg = r.wreg && !ov;
    e.store_data = b;
    return e;
  endfunction

  task automatic check_result(input ex_res_t got, input ex_res_t exp);
    compare_word("aluop", word_t'(got.aluop), word_t'(exp.aluop));
    compare_word("wd", word_t'(got.wd), word_t'(exp.wd));
    compare_word("wreg", word_t'(got.wreg), word_t'(exp.wreg));
    compare_word("wdata", got.wdata, exp.wdata);
    compare_word("mem_addr", got.mem_addr, exp.mem_addr);
    compare_word("store_data", got.store_data, exp.store_data);
    compare_exc("exc", got.exc, exp.exc);
  endtask

  // hold valid until the stage takes the request
  task automatic send(input ex_req_t r);
    req_i = r;
    req_valid_i = 1'b1;
    do
    begin
      @(negedge clk);
    end
    while (!req_ready_o);
    exp_q.push_back(model(r));
    @(posedge clk);
    #1;
    req_valid_i = 1'b0;
  endtask

  task automatic drain();
    while (exp_q.size() != 0)
      @(negedge clk);
    @(posedge clk);
    #1;
  endtask

  task automatic logic_and_shift();
    aluop_e lops[4] = '{OP_OR, OP_AND, OP_NOR, OP_XOR};
    aluop_e sops[3] = '{OP_SLL, OP_SRL, OP_SRA};
    for (int i = 0; i < 6; i++)
    begin
      foreach (lops[k])
        send(build_req(lops[k], SEL_LOGIC, rand_word(), rand_word()));
      foreach (sops[k])
        send(build_req(sops[k], SEL_SHIFT, rand_word(), rand_word()));
      // negative operand for the sign fill
      send(build_req(OP_SRA, SEL_SHIFT, rand_word(), rand_word() | 32'h8000_0000));
    end
    drain();
  endtask

  task automatic arith_and_count();
    word_t  edges[4] = '{32'h0000_0000, 32'h7fff_ffff, 32'h8000_0000, 32'hffff_ffff};
    aluop_e aops[4] = '{OP_ADDU, OP_SUBU, OP_SLT, OP_SLTU};
    foreach (aops[k])
    begin
      foreach (edges[i])
        foreach (edges[j])
          send(build_req(aops[k], SEL_ARITH, edges[i], edges[j]));
      for (int i = 0; i < 4; i++)
        send(build_req(aops[k], SEL_ARITH, rand_word(), rand_word()));
    end
    send(build_req(OP_CLZ, SEL_ARITH, '0, '0));
    send(build_req(OP_CLO, SEL_ARITH, '0, '0));
    send(build_req(OP_CLZ, SEL_ARITH, '1, '0));
    send(build_req(OP_CLO, SEL_ARITH, '1, '0));
    for (int i = 0; i < `REG_W; i += 3)
    begin
      send(build_req(OP_CLZ, SEL_ARITH, word_t'(1) << i, '0));
      send(build_req(OP_CLO, SEL_ARITH, ~(word_t'(1) << i), '0));
    end
    for (int i = 0; i < 3; i++)
      send(build_req(OP_NOP, SEL_JUMP_BRANCH, rand_word(), rand_word()));
    drain();
  endtask

  task automatic overflow_gating();
    word_t  oa[6] = '{32'h7fff_ffff, 32'h8000_0000, 32'h8000_0000, 32'h7fff_ffff, 32'd5,
                      32'h0000_0000};
    word_t  ob[6] = '{32'h0000_0001, 32'hffff_ffff, 32'h0000_0001, 32'hffff_ffff, 32'd9,
                      32'h8000_0000};
    aluop_e oops[6] = '{OP_ADD, OP_ADD, OP_SUB, OP_SUB, OP_SUB, OP_SUB};
    foreach (oops[k])
    begin
      send(build_req(oops[k], SEL_ARITH, oa[k], ob[k]));
      send(build_req(OP_ADDU, SEL_ARITH, oa[k], ob[k]));
    end
    drain();
  endtask

  task automatic trap_conditions();
    word_t   ta[5] = '{32'd5, 32'd3, 32'd7, 32'hffff_ffff, 32'd1};
    word_t   tb[5] = '{32'd5, 32'd7, 32'd3, 32'd1, 32'hffff_ffff};
    aluop_e  tops[6] = '{OP_TEQ, OP_TNE, OP_TGE, OP_TGEU, OP_TLT, OP_TLTU};
    ex_req_t r;
    foreach (tops[k])
      foreach (ta[i])
      begin
        r = build_req(tops[k], SEL_NONE, ta[i], tb[i]);
        r.wreg = 1'b0;
        // decode exception bits that must ride through
        r.exc_in = (i % 2 == 1) ? 32'h0000_0101 : '0;
        send(r);
      end
    drain();
  endtask

  task automatic load_store_addr();
    aluop_e              mops[7] = '{OP_LB, OP_LH, OP_LHU, OP_LW, OP_SB, OP_SH, OP_SW};
    logic [`OFFSET_W-1:0] offs[6] = '{16'h0000, 16'h0001, 16'h0002, 16'h0003,
                                      16'hfffe, 16'h8001};
    ex_req_t             r;
    foreach (mops[k])
      foreach (offs[i])
      begin
        r = build_req(mops[k], SEL_NONE, rand_word() & 32'hffff_fffc, rand_word());
        r.offset = offs[i];
        r.wreg = mops[k] inside {OP_LB, OP_LH, OP_LHU, OP_LW};
        send(r);
      end
    drain();
  endtask

  task automatic backpressure_stream();
    aluop_e  bops[4] = '{OP_OR, OP_ADDU, OP_SLTU, OP_SLL};
    alusel_e bsel[4] = '{SEL_LOGIC, SEL_ARITH, SEL_ARITH, SEL_SHIFT};
    word_t   pick;
    stall_en = 1'b1;
    for (int i = 0; i < 40; i++)
    begin
      pick = rand_word();
      send(build_req(bops[pick[1:0]], bsel[pick[1:0]], rand_word(), rand_word()));
    end
    drain();
    stall_en = 1'b0;
  endtask

  // memory stage readiness, random while stalling
  always @(posedge clk)
  begin
    word_t r;
    #1;
    r = rand_word();
    res_ready_i = stall_en ? r[0] : 1'b1;
  end

  // in-order result check and hold check under back-pressure
  always @(posedge clk)
  begin
    if (rst_n_i)
    begin
      if (held_v && !res_valid_o)
        report_failure("res_valid_o dropped before the result was taken");
      if (held_v && res_o !== held)
        report_failure("res_o changed while res_ready_i was low");
      if (res_valid_o && res_ready_i)
      begin
        if (exp_q.size() == 0)
          report_failure("result delivered with no request outstanding");
        else
          check_result(res_o, exp_q.pop_front());
      end
      held_v = res_valid_o && !res_ready_i;
      held = res_o;
    end
  end

  always @(posedge clk)
  begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES)
      report_failure("timeout, the run did not finish within the cycle limit");
  end

  initial
  begin
    seed = 32'hcb0d7aca;
    clk = 1'b0;
    rst_n_i = 1'b0;
    req_i = '0;
    req_valid_i = 1'b0;
    res_ready_i = 1'b1;
    stall_en = 1'b0;
    held_v = 1'b0;
    held = '0;
    repeat (3) @(posedge clk);
    #1;
    rst_n_i = 1'b1;
    compare_word("res_valid_o", word_t'(res_valid_o), '0);
    compare_word("req_ready_o", word_t'(req_ready_o), word_t'(1));
    logic_and_shift();
    arith_and_count();
    overflow_gating();
    trap_conditions();
    load_store_addr();
    backpressure_stream();
    if (exp_q.size() != 0)
    begin
      report_failure("results still outstanding at the end of the run");
    end
    else
    begin
      $display("TEST PASSED");
      $finish;
    end
  end

endmodule

/* project.f */
+incdir+verilog
verilog/ex_pkg.sv
verilog/ex_adder_cmp.sv
verilog/ex_alu.sv
verilog/ex_except.sv
verilog/ex_mem_reg.sv
verilog/ex_top.sv
verification/ex_tb.sv

/* run.sh */
#!/bin/sh
# build the execute stage testbench with Verilator, run it, then check the log
rm -f sim.log &&
verilator --binary --timescale 1ns/1ps --top-module ex_tb -f project.f -o ex_tb_sim &&
./obj_dir/ex_tb_sim > sim.log 2>&1
grep -q "TEST PASSED" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
